// File: rtl/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and instruction widths
`define CPU_DATA_W      8
`define CPU_INSTR_W     16

// memory depths in words
`define CPU_IMEM_DEPTH  256
`define CPU_DMEM_DEPTH  256

// architectural registers
`define CPU_REG_COUNT   8

// beats the output stream may have outstanding
`define CPU_OUT_CREDITS 4

`endif

// File: rtl/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0]                     data_t;
    typedef logic [`CPU_INSTR_W-1:0]                    instr_t;
    typedef logic [$clog2(`CPU_IMEM_DEPTH)-1:0]         pc_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0]          reg_addr_t;
    typedef logic [$clog2(`CPU_OUT_CREDITS + 1)-1:0]    credit_t;

    // instr[15:12]
    typedef enum logic [3:0] {
        NOP   = 4'd0,
        MOVIR = 4'd1,
        MOVRR = 4'd2,
        LOAD  = 4'd3,
        STORE = 4'd4,
        ADDRR = 4'd5,
        ADDI  = 4'd6,
        SUBRR = 4'd7,
        SUBI  = 4'd8,
        JZI   = 4'd9,
        JZR   = 4'd10,
        OUT   = 4'd11,
        HALT  = 4'd12
    } opcode_e;

    // fetch to decode
    typedef struct packed {
        logic   valid;
        pc_t    pc;
        instr_t instr;
    } fetch_pkt_t;

    // decode to execute with the operands already read
    typedef struct packed {
        logic      valid;
        opcode_e   op;
        reg_addr_t rd;
        data_t     a;
        data_t     b;
        data_t     imm;
    } exec_pkt_t;

    typedef enum logic [1:0] {
        IDLE,
        RUNNING,
        HALTED
    } run_state_e;

endpackage

// File: rtl/register_file.sv
`include "cpu_defines.svh"

module register_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    output data_t     rd_data_a,
    output data_t     rd_data_b,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  data_t     wr_data
);

    data_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle write shows up on the read ports
    assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

// File: rtl/fetch_stage.sv
`include "cpu_defines.svh"

module fetch_stage
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       run,
    input  logic       halt_req,
    input  logic       stall,
    input  logic       redirect,
    input  pc_t        redirect_pc,
    input  logic       prog_we,
    input  pc_t        prog_addr,
    input  instr_t     prog_data,
    output fetch_pkt_t fetch_out,
    output logic       halted
);

    instr_t     imem [`CPU_IMEM_DEPTH];
    pc_t        pc;
    run_state_e state;

    // host loads the program while the core is stopped
    always_ff @(posedge clk) begin
        if (prog_we && !run) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            pc        <= '0;
            fetch_out <= '0;
        end else begin
            case (state)
                IDLE: begin
                    fetch_out.valid <= 1'b0;
                    pc              <= '0;
                    if (run) begin
                        state <= RUNNING;
                    end
                end
                RUNNING: begin
                    if (!run) begin
                        state           <= IDLE;
                        fetch_out.valid <= 1'b0;
                    end else if (halt_req) begin
                        state           <= HALTED;
                        fetch_out.valid <= 1'b0;
                    end else if (redirect) begin
                        pc              <= redirect_pc;
                        fetch_out.valid <= 1'b0;
                    end else if (!stall) begin
                        fetch_out <= '{valid: 1'b1, pc: pc, instr: imem[pc]};
                        pc        <= pc + pc_t'(1);
                    end
                end
                HALTED: begin
                    fetch_out.valid <= 1'b0;
                    if (!run) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign halted = (state == HALTED);

    // program port only usable while stopped
    a_no_prog_while_run: assert property (
        @(posedge clk) disable iff (!arst_n) prog_we |-> !run
    );

endmodule

// File: rtl/decode_stage.sv
module decode_stage
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       stall,
    input  logic       flush,
    input  fetch_pkt_t fetch_in,
    output reg_addr_t  rd_addr_a,
    output reg_addr_t  rd_addr_b,
    input  data_t      rd_data_a,
    input  data_t      rd_data_b,
    output exec_pkt_t  exec_out
);

    logic [3:0] op_raw;
    opcode_e    op;
    reg_addr_t  f_rd;
    reg_addr_t  f_rs;
    reg_addr_t  f_rt;
    data_t      f_imm;

    // instruction fields
    assign op_raw = fetch_in.instr[15:12];
    assign f_rd   = fetch_in.instr[10:8];
    assign f_rs   = fetch_in.instr[6:4];
    assign f_rt   = fetch_in.instr[2:0];
    assign f_imm  = fetch_in.instr[7:0];

    // opcodes past HALT are undefined and run as nop
    always_comb begin
        if (op_raw > 4'(HALT)) begin
            op = NOP;
        end else begin
            op = opcode_e'(op_raw);
        end
    end

    // ops that work on rd read it through port a
    always_comb begin
        case (op)
            ADDI,
            SUBI,
            STORE,
            OUT,
            JZR:     rd_addr_a = f_rd;
            default: rd_addr_a = f_rs;
        endcase
    end

    assign rd_addr_b = f_rt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exec_out <= '0;
        end else if (flush) begin
            exec_out.valid <= 1'b0;
        end else if (!stall) begin
            exec_out.valid <= fetch_in.valid;
            exec_out.op    <= op;
            exec_out.rd    <= f_rd;
            exec_out.a     <= rd_data_a;
            exec_out.b     <= rd_data_b;
            exec_out.imm   <= f_imm;
        end
    end

    // back-to-back packets from fetch come in pc order
    a_pc_sequence: assert property (
        @(posedge clk) disable iff (!arst_n)
        (fetch_in.valid && !stall && !flush) ##1 fetch_in.valid
            |-> fetch_in.pc == pc_t'($past(fetch_in.pc) + 1'b1)
    );

endmodule

// File: rtl/execute_stage.sv
`include "cpu_defines.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  exec_pkt_t exec_in,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output data_t     wr_data,
    output logic      stall,
    output logic      redirect,
    output pc_t       redirect_pc,
    output logic      halt_req,
    output logic      out_valid,
    output data_t     out_data,
    input  logic      out_credit
);

    data_t   dmem [`CPU_DMEM_DEPTH];
    logic    zero_flag;
    logic    set_zero;
    logic    jump_taken;
    logic    is_out;
    logic    has_credit;
    credit_t credit_cnt;

    always_comb begin
        wr_data     = '0;
        wr_en       = 1'b0;
        set_zero    = 1'b0;
        jump_taken  = 1'b0;
        redirect_pc = pc_t'(exec_in.imm);
        case (exec_in.op)
            MOVIR: begin
                wr_data  = exec_in.imm;
                wr_en    = 1'b1;
                set_zero = 1'b1;
            end
            MOVRR: begin
                wr_data  = exec_in.a;
                wr_en    = 1'b1;
                set_zero = 1'b1;
            end
            LOAD: begin
                wr_data = dmem[exec_in.imm];
                wr_en   = 1'b1;
            end
            ADDRR: begin
                wr_data  = exec_in.a + exec_in.b;
                wr_en    = 1'b1;
                set_zero = 1'b1;
            end
            ADDI: begin
                wr_data  = exec_in.a + exec_in.imm;
                wr_en    = 1'b1;
                set_zero = 1'b1;
            end
            SUBRR: begin
                wr_data  = exec_in.a - exec_in.b;
                wr_en    = 1'b1;
                set_zero = 1'b1;
            end
            SUBI: begin
                wr_data  = exec_in.a - exec_in.imm;
                wr_en    = 1'b1;
                set_zero = 1'b1;
            end
            JZI: begin
                jump_taken = zero_flag;
            end
            JZR: begin
                jump_taken  = zero_flag;
                redirect_pc = pc_t'(exec_in.a);
            end
            default: begin
            end
        endcase
        // bubbles do nothing
        if (!exec_in.valid) begin
            wr_en      = 1'b0;
            set_zero   = 1'b0;
            jump_taken = 1'b0;
        end
    end

    assign wr_addr  = exec_in.rd;
    assign halt_req = exec_in.valid && (exec_in.op == HALT);

    // halt also flushes the younger instructions
    assign redirect = jump_taken || halt_req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            zero_flag <= 1'b0;
        end else if (set_zero) begin
            zero_flag <= (wr_data == '0);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (exec_in.valid && exec_in.op == STORE) begin
            dmem[exec_in.imm] <= exec_in.a;
        end
    end

    // each output beat spends one credit
    assign is_out     = exec_in.valid && (exec_in.op == OUT);
    assign has_credit = (credit_cnt != '0);
    assign out_valid  = is_out && has_credit;
    assign out_data   = exec_in.a;
    assign stall      = is_out && !has_credit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= credit_t'(`CPU_OUT_CREDITS);
        end else begin
            case ({out_valid, out_credit})
                2'b10: credit_cnt <= credit_cnt - credit_t'(1);
                2'b01: begin
                    if (credit_cnt != credit_t'(`CPU_OUT_CREDITS)) begin
                        credit_cnt <= credit_cnt + credit_t'(1);
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // a credit pulse while full would push the count past its range
    a_credit_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_credit && !out_valid |-> credit_cnt != credit_t'(`CPU_OUT_CREDITS)
    );

    // no beat follows the last credit until one comes back
    a_no_beat_without_credit: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid && !out_credit && credit_cnt == credit_t'(1) |=> !out_valid
    );

endmodule

// File: rtl/cpu_top.sv
module cpu_top
    import cpu_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   run,
    input  logic   prog_we,
    input  pc_t    prog_addr,
    input  instr_t prog_data,
    output logic   halted,
    output logic   out_valid,
    output data_t  out_data,
    input  logic   out_credit
);

    fetch_pkt_t fetch_pkt;
    exec_pkt_t  exec_pkt;
    reg_addr_t  rd_addr_a;
    reg_addr_t  rd_addr_b;
    data_t      rd_data_a;
    data_t      rd_data_b;
    logic       wr_en;
    reg_addr_t  wr_addr;
    data_t      wr_data;
    logic       stall;
    logic       redirect;
    pc_t        redirect_pc;
    logic       halt_req;

    fetch_stage u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .halt_req    (halt_req),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .fetch_out   (fetch_pkt),
        .halted      (halted)
    );

    // a redirect squashes whatever decode holds
    decode_stage u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .flush     (redirect),
        .fetch_in  (fetch_pkt),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .exec_out  (exec_pkt)
    );

    register_file u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    execute_stage u_execute (
        .clk         (clk),
        .arst_n      (arst_n),
        .exec_in     (exec_pkt),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halt_req    (halt_req),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_credit  (out_credit)
    );

endmodule

// File: dv/cpu_tb.sv
`include "cpu_defines.svh"

module cpu_tb
    import cpu_pkg::*;
();

    localparam int NUM_TESTS  = 6;
    localparam int WAIT_LIMIT = 2000;

    logic   clk;
    logic   arst_n;
    logic   run;
    logic   prog_we;
    pc_t    prog_addr;
    instr_t prog_data;
    logic   halted;
    logic   out_valid;
    data_t  out_data;
    logic   out_credit;

    string  names [NUM_TESTS];
    instr_t progs [NUM_TESTS][16];
    data_t  exp_vals [NUM_TESTS][8];
    int     exp_count [NUM_TESTS];

    data_t       beats [$];
    int          credit_due [$];
    int          cycle = 0;
    int          sent = 0;
    int          returned = 0;
    int          test_errors = 0;
    logic [15:0] lfsr = 16'd24;

    cpu_top dut_i (.*);

    always #10 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            test_errors++;
        end
    endtask

    // beats are sampled mid-cycle and each schedules a credit 2 to 17 cycles later
    always @(negedge clk) begin
        logic [3:0] delay;
        if (out_valid === 1'b1) begin
            beats.push_back(out_data);
            sent++;
            for (int i = 0; i < 4; i++) begin
                lfsr  = lfsr_step(lfsr);
                delay = {delay[2:0], lfsr[0]};
            end
            credit_due.push_back(cycle + 2 + int'(delay));
            if (sent - returned > `CPU_OUT_CREDITS) begin
                $display("output stream has %0d beats outstanding, more than its credits",
                         sent - returned);
                test_errors++;
            end
        end
    end

    // consumer returns at most one credit per cycle
    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            // the DUT takes the pulse at this edge
            if (out_credit) begin
                returned++;
            end
            #2;
            cycle++;
            if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
                void'(credit_due.pop_front());
                out_credit = 1'b1;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    task automatic load_table();
        // MOVIR r1,5A; MOVIR r2,03; MOVRR r3,r1; OUT r1; OUT r2; OUT r3; HALT
        names[0]     = "move";
        progs[0]     = '{16'h115A, 16'h1203, 16'h2310, 16'hB100, 16'hB200, 16'hB300,
                         16'hC000, 16'hC000, 16'hC000, 16'hC000, 16'hC000, 16'hC000,
                         16'hC000, 16'hC000, 16'hC000, 16'hC000};
        exp_vals[0]  = '{8'h5A, 8'h03, 8'h5A, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
        exp_count[0] = 3;
        // 250+10, 10-250, 250+7, 10-3
        names[1]     = "arith";
        progs[1]     = '{16'h11FA, 16'h120A, 16'h5312, 16'hB300, 16'h7421, 16'hB400,
                         16'h6107, 16'hB100, 16'h8203, 16'hB200, 16'hC000, 16'hC000,
                         16'hC000, 16'hC000, 16'hC000, 16'hC000};
        exp_vals[1]  = '{8'h04, 8'h10, 8'h01, 8'h07, 8'h00, 8'h00, 8'h00, 8'h00};
        exp_count[1] = 4;
        // store r1 at 0x40, load it back into r5
        names[2]     = "store_load";
        progs[2]     = '{16'h11A7, 16'h4140, 16'h3540, 16'hB500, 16'hC000, 16'hC000,
                         16'hC000, 16'hC000, 16'hC000, 16'hC000, 16'hC000, 16'hC000,
                         16'hC000, 16'hC000, 16'hC000, 16'hC000};
        exp_vals[2]  = '{8'hA7, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
        exp_count[2] = 1;
        // JZI taken over word 4, JZI not taken at 7, JZR via r6=12 over word 11
        names[3]     = "jump";
        progs[3]     = '{16'h160C, 16'h1105, 16'h8105, 16'h9005, 16'hB100, 16'h1211,
                         16'h8201, 16'h9009, 16'hB200, 16'h8210, 16'hA600, 16'hB200,
                         16'h1333, 16'hB300, 16'hC000, 16'hC000};
        exp_vals[3]  = '{8'h10, 8'h33, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
        exp_count[3] = 2;
        // eight OUTs back to back against four credits
        names[4]     = "backpressure";
        progs[4]     = '{16'h1161, 16'h1262, 16'h1363, 16'h1464, 16'hB100, 16'hB200,
                         16'hB300, 16'hB400, 16'hB400, 16'hB300, 16'hB200, 16'hB100,
                         16'hC000, 16'hC000, 16'hC000, 16'hC000};
        exp_vals[4]  = '{8'h61, 8'h62, 8'h63, 8'h64, 8'h64, 8'h63, 8'h62, 8'h61};
        exp_count[4] = 8;
        // nothing behind the HALT may reach the stream
        names[5]     = "halt";
        progs[5]     = '{16'h1177, 16'hB100, 16'hC000, 16'hB100, 16'h1299, 16'hB200,
                         16'hB100, 16'hC000, 16'hC000, 16'hC000, 16'hC000, 16'hC000,
                         16'hC000, 16'hC000, 16'hC000, 16'hC000};
        exp_vals[5]  = '{8'h77, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
        exp_count[5] = 1;
    endtask

    task automatic run_test(input int t);
        int waited;
        run = 1'b0;
        // fetch drops back to idle
        @(posedge clk);
        #2;
        for (int i = 0; i < 16; i++) begin
            prog_we   = 1'b1;
            prog_addr = pc_t'(i);
            prog_data = progs[t][i];
            @(posedge clk);
            #2;
        end
        prog_we = 1'b0;
        beats.delete();
        run    = 1'b1;
        waited = 0;
        while (!halted && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!halted) begin
            $display("%s: halted did not rise within %0d cycles", names[t], WAIT_LIMIT);
            test_errors++;
        end
        // room for any stray beat
        repeat (4) @(posedge clk);
        #2;
        check_value({names[t], " beat count"}, exp_count[t], beats.size());
        for (int i = 0; i < exp_count[t] && i < beats.size(); i++) begin
            check_value($sformatf("%s beat %0d", names[t], i),
                        int'(exp_vals[t][i]), int'(beats[i]));
        end
    endtask

    initial begin
        int passed;
        int failed;
        clk       = 1'b0;
        arst_n    = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        passed    = 0;
        failed    = 0;
        load_table();
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors = 0;
            run_test(t);
            if (test_errors == 0) begin
                passed++;
                $display("PASS %s", names[t]);
            end else begin
                failed++;
                $display("FAIL %s with %0d errors", names[t], test_errors);
            end
        end
        $display("tests run %0d, passed %0d, failed %0d", NUM_TESTS, passed, failed);
        if (failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/register_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/cpu_top.sv
dv/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
